//--- wb_shared_ram_top.f
+incdir+.
wb_pkg.sv
wb_arbiter.sv
arbiter2_wb.sv
wb_ram.sv
wb_shared_ram_top.sv
wb_shared_ram_tb.sv

//--- Makefile
TOP = wb_shared_ram_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f wb_shared_ram_top.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- wb_shared_ram_tb.sv
// Directed testbench for the shared RAM subsystem with reference memory, check task and watchdog
`default_nettype none

`include "wb_defs.svh"

module wb_shared_ram_tb;

    typedef logic [`WB_ADDR_WIDTH-1:0] adr_t;
    typedef logic [`WB_DATA_WIDTH-1:0] dat_t;
    typedef logic [`WB_SEL_WIDTH-1:0]  sel_t;

    localparam int MAX_CYCLES = 3000;  // Whole run needs a few hundred cycles
    localparam int N_WORDS    = 16;    // Words touched by the random passes

    logic            clk;
    logic            reset_i;
    wb_pkg::wb_req_t m0_req;
    wb_pkg::wb_rsp_t m0_rsp;
    wb_pkg::wb_req_t m1_req;
    wb_pkg::wb_rsp_t m1_rsp;

    dat_t ref_mem [`WB_RAM_DEPTH];     // Expected RAM contents
    adr_t used_adr [N_WORDS];          // Addresses with known contents
    int   cycle_count  = 0;
    int   errors       = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    int   test_start_errors = 0;

    wb_shared_ram_top dut_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .m0_req_i (m0_req),
        .m0_rsp_o (m0_rsp),
        .m1_req_i (m1_req),
        .m1_rsp_o (m1_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;               // Period 100
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_value(input dat_t actual, input dat_t expected, input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic drive_req(input int m, input wb_pkg::wb_req_t req);
        if (m == 0) begin
            m0_req <= req;
        end else begin
            m1_req <= req;
        end
    endtask

    function automatic logic ack_of(input int m);
        return (m == 0) ? m0_rsp.ack : m1_rsp.ack;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        m0_req  <= '0;
        m1_req  <= '0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
    endtask

    // One strobe, then the cycle ends or stays locked with stb low
    task automatic strobe(input int m, input logic we, input adr_t adr, input dat_t dat,
                          input sel_t sel, input logic keep_cyc,
                          output dat_t rdat, output int wait_cycles);
        wb_pkg::wb_req_t req;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        @(posedge clk);
        drive_req(m, req);
        wait_cycles = 0;
        @(negedge clk);                        // Sample mid cycle
        while (!ack_of(m)) begin
            wait_cycles++;
            @(negedge clk);
        end
        rdat    = (m == 0) ? m0_rsp.dat : m1_rsp.dat;
        req     = '0;
        req.cyc = keep_cyc;
        @(posedge clk);
        drive_req(m, req);
    endtask

    // Strobe plus reference model update or read check
    task automatic access(input int m, input logic we, input adr_t adr, input dat_t dat,
                          input sel_t sel, input logic keep_cyc, output int wait_cycles);
        dat_t rdat;
        strobe(m, we, adr, dat, sel, keep_cyc, rdat, wait_cycles);
        if (we) begin
            for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
                if (sel[b]) begin
                    ref_mem[adr][b*8 +: 8] = dat[b*8 +: 8];   // Byte merge
                end
            end
        end else begin
            check_value(rdat, ref_mem[adr], $sformatf("master %0d read at %h", m, adr));
        end
    endtask

    task automatic watch_no_ack(input int m, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value(dat_t'(ack_of(m)), '0, $sformatf("ack to idle master %0d", m));
        end
    endtask

    task automatic first_ack(output int m);
        @(negedge clk);
        while (!(m0_rsp.ack || m1_rsp.ack)) begin
            @(negedge clk);
        end
        m = m0_rsp.ack ? 0 : 1;
    endtask

    // Master 1 ack must come after master 0 has left the bus
    task automatic expect_m1_after_m0();
        @(negedge clk);
        while (!m1_rsp.ack) begin
            @(negedge clk);
        end
        check_value(dat_t'(m0_req.cyc), '0, "master 1 acked while master 0 held the bus");
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d checks failed", name, errors - test_start_errors);
        end
    endtask

    task automatic test_idle_after_reset();
        begin_test();
        fork
            watch_no_ack(0, 8);
            watch_no_ack(1, 8);
        join
        end_test("idle after reset");
    endtask

    task automatic test_write_read();
        int w;
        begin_test();
        for (int i = 0; i < N_WORDS; i++) begin
            used_adr[i] = adr_t'($urandom);
            access(0, 1'b1, used_adr[i], dat_t'($urandom), '1, 1'b0, w);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            access(1, 1'b0, used_adr[i], '0, '1, 1'b0, w);   // Read back by the other master
        end
        end_test("write then read back");
    endtask

    task automatic test_byte_select();
        int w;
        begin_test();
        for (int i = 0; i < N_WORDS; i++) begin
            access(i % 2, 1'b1, used_adr[i], dat_t'($urandom), sel_t'($urandom), 1'b0, w);
            access(1 - (i % 2), 1'b0, used_adr[i], '0, '1, 1'b0, w);
        end
        end_test("byte select merge");
    endtask

    task automatic test_latency();
        int w;
        begin_test();
        repeat (3) @(posedge clk);             // Let the grant go idle
        fork
            access(0, 1'b0, used_adr[0], '0, '1, 1'b0, w);
            watch_no_ack(1, 6);
        join
        check_value(w, 2, "master 0 latency from idle");
        repeat (3) @(posedge clk);
        fork
            access(1, 1'b1, used_adr[1], dat_t'($urandom), '1, 1'b0, w);
            watch_no_ack(0, 6);
        join
        check_value(w, 2, "master 1 latency from idle");
        end_test("latency");
    endtask

    task automatic test_round_robin();
        int w0;
        int w1;
        int first;
        int expected_first;
        int last_winner;
        begin_test();
        apply_reset();
        last_winner = 1;                       // Master 0 favored after reset
        for (int r = 0; r < 4; r++) begin
            expected_first = 1 - last_winner;  // Last winner drops to lowest
            fork
                access(0, 1'b1, used_adr[r], dat_t'($urandom), '1, 1'b0, w0);
                access(1, 1'b0, used_adr[r + 4], '0, '1, 1'b0, w1);
                first_ack(first);
            join
            check_value(first, expected_first, $sformatf("first ack in round %0d", r));
            last_winner = 1 - expected_first;  // Other master served second
        end
        end_test("round robin");
    endtask

    task automatic test_bus_lock();
        int w0;
        int w1;
        begin_test();
        repeat (2) @(posedge clk);
        fork
            begin
                for (int s = 0; s < 4; s++) begin
                    access(0, (s % 2) == 0, used_adr[8 + s / 2], dat_t'($urandom), '1,
                           s != 3, w0);
                    if (s > 0) begin
                        check_value(w0, 1, $sformatf("locked strobe %0d latency", s));
                    end
                end
            end
            begin
                @(posedge clk);                // Request lands while master 0 owns the bus
                access(1, 1'b0, used_adr[15], '0, '1, 1'b0, w1);
            end
            expect_m1_after_m0();
        join
        end_test("bus lock");
    endtask

    initial begin
        reset_i <= 1'b1;
        m0_req  <= '0;
        m1_req  <= '0;
        void'($urandom(32'h0bbe_7589));
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        test_idle_after_reset();
        test_write_read();
        test_byte_select();
        test_latency();
        test_round_robin();
        test_bus_lock();
        repeat (2) @(posedge clk);
        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : wb_shared_ram_tb

`default_nettype wire

//--- wb_shared_ram_top.sv
// Top level with two Wishbone masters sharing one RAM through arbiter2_wb
`default_nettype none

`include "wb_defs.svh"

module wb_shared_ram_top (
    input  wire             clk,
    input  wire             reset_i,
    input  wire  wb_pkg::wb_req_t m0_req_i,
    output wb_pkg::wb_rsp_t       m0_rsp_o,
    input  wire  wb_pkg::wb_req_t m1_req_i,
    output wb_pkg::wb_rsp_t       m1_rsp_o
);

    wb_pkg::wb_req_t slv_req;  // Owner's request toward the RAM
    wb_pkg::wb_rsp_t slv_rsp;  // RAM response toward both masters

    // Round robin, so neither master starves
    arbiter2_wb #(
        .ROUND_ROBIN       (1'b1),
        .LSB_HIGH_PRIORITY (1'b0)
    ) arb_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .m0_req_i (m0_req_i),
        .m0_rsp_o (m0_rsp_o),
        .m1_req_i (m1_req_i),
        .m1_rsp_o (m1_rsp_o),
        .s_req_o  (slv_req),
        .s_rsp_i  (slv_rsp)
    );

    wb_ram ram_i (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (slv_req),
        .rsp_o   (slv_rsp)
    );

endmodule : wb_shared_ram_top

`default_nettype wire

//--- wb_ram.sv
// Wishbone classic single-port RAM slave with byte selects and registered ack
`default_nettype none

`include "wb_defs.svh"

module wb_ram (
    input  wire             clk,
    input  wire             reset_i,
    input  wire  wb_pkg::wb_req_t req_i,   // From the arbiter
    output wb_pkg::wb_rsp_t       rsp_o    // Back to the arbiter
);

    localparam int unsigned NUM_BYTES = `WB_SEL_WIDTH;

    logic [`WB_DATA_WIDTH-1:0] mem [`WB_RAM_DEPTH];  // Storage, contents undefined at start
    logic [`WB_DATA_WIDTH-1:0] rdat_q;               // Read word, presented with ack
    logic                      ack_q;                // One-cycle acknowledge
    logic                      access;               // Strobe accepted this edge

    // New strobe only, the acked one must not retrigger
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;                         // Pulse, drops the next edge
        end
    end

    // Array and data path
    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                for (int b = 0; b < NUM_BYTES; b++) begin
                    if (req_i.sel[b]) begin
                        mem[req_i.adr][b*`WB_BYTE_WIDTH +: `WB_BYTE_WIDTH] <=
                            req_i.dat[b*`WB_BYTE_WIDTH +: `WB_BYTE_WIDTH];
                    end
                end
            end
            rdat_q <= mem[req_i.adr];                // Old word on a write cycle
        end
    end

    assign rsp_o.dat = rdat_q;
    assign rsp_o.ack = ack_q;

    // Every ack answers a strobe from the cycle before
    a_ack_has_strobe : assert property (
        @(posedge clk) disable iff (reset_i)
        rsp_o.ack |-> $past(req_i.cyc && req_i.stb)
    ) else $error("wb_ram: ack without a preceding strobe");

endmodule : wb_ram

`default_nettype wire

//--- arbiter2_wb.sv
// Wishbone two-master arbiter, granted master muxed onto the slave port, ack routed back
`default_nettype none

`include "wb_defs.svh"

module arbiter2_wb #(
    parameter bit ROUND_ROBIN       = 1'b0,  // Passed to the arbiter core
    parameter bit LSB_HIGH_PRIORITY = 1'b0   // Passed to the arbiter core
) (
    input  wire             clk,
    input  wire             reset_i,

    // Master 0 side
    input  wire  wb_pkg::wb_req_t m0_req_i,
    output wb_pkg::wb_rsp_t       m0_rsp_o,

    // Master 1 side
    input  wire  wb_pkg::wb_req_t m1_req_i,
    output wb_pkg::wb_rsp_t       m1_rsp_o,

    // Shared slave side
    output wb_pkg::wb_req_t       s_req_o,
    input  wire  wb_pkg::wb_rsp_t s_rsp_i
);

    logic [1:0] request;      // Cycle lines as requests
    logic [1:0] grant;        // One-hot from the core
    logic       grant_valid;
    logic       m0_sel;       // Master 0 owns the slave
    logic       m1_sel;       // Master 1 owns the slave

    assign request = {m1_req_i.cyc, m0_req_i.cyc};

    wb_arbiter #(
        .ROUND_ROBIN       (ROUND_ROBIN),
        .LSB_HIGH_PRIORITY (LSB_HIGH_PRIORITY)
    ) arb_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .request_i     (request),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    assign m0_sel = grant[0] & grant_valid;
    assign m1_sel = grant[1] & grant_valid;

    // Slave request follows the owner, idle bus when nobody owns it
    always_comb begin
        if (m0_sel) begin
            s_req_o = m0_req_i;
        end else if (m1_sel) begin
            s_req_o = m1_req_i;
        end else begin
            s_req_o = '0;
        end
    end

    // Read data to both, ack only to the owner
    always_comb begin
        m0_rsp_o.dat = s_rsp_i.dat;
        m0_rsp_o.ack = s_rsp_i.ack & m0_sel;
        m1_rsp_o.dat = s_rsp_i.dat;
        m1_rsp_o.ack = s_rsp_i.ack & m1_sel;
    end

    // Relies on the core grant staying one-hot
    a_ack_exclusive : assert property (
        @(posedge clk) disable iff (reset_i)
        !(m0_rsp_o.ack && m1_rsp_o.ack)
    ) else $error("arbiter2_wb: both masters acknowledged");

endmodule : arbiter2_wb

`default_nettype wire

//--- wb_arbiter.sv
// Two-requester arbiter with blocking grant, fixed-priority or round-robin selection
`default_nettype none

`include "wb_defs.svh"

module wb_arbiter #(
    parameter bit ROUND_ROBIN       = 1'b0,  // Last winner drops to lowest priority
    parameter bit LSB_HIGH_PRIORITY = 1'b0   // Index 0 beats index 1 in plain priority
) (
    input  wire        clk,
    input  wire        reset_i,
    input  wire  [1:0] request_i,      // One bit per requester
    output logic [1:0] grant_o,        // One-hot, registered
    output logic       grant_valid_o   // Some requester holds the grant
);

    logic [1:0] grant_q;     // Current holder
    logic       valid_q;     // Registered alongside the grant
    logic [1:0] mask_q;      // Requesters that did not win last
    logic [1:0] grant_d;     // Next grant
    logic [1:0] masked_req;  // Requests still eligible this round
    logic       hold;        // Holder keeps requesting

    // Plain priority pick among the given requests
    function automatic logic [1:0] pick(input logic [1:0] req);
        logic [1:0] sel;
        if (LSB_HIGH_PRIORITY) begin
            sel = req[0] ? 2'b01 : {req[1], 1'b0};   // Index 0 first
        end else begin
            sel = req[1] ? 2'b10 : {1'b0, req[0]};   // Index 1 first
        end
        return sel;
    endfunction

    assign hold       = |(grant_q & request_i);  // Blocking, release on request drop
    assign masked_req = request_i & mask_q;

    always_comb begin
        if (hold) begin
            grant_d = grant_q;                   // Keep the current owner
        end else if (ROUND_ROBIN && (|masked_req)) begin
            grant_d = pick(masked_req);          // Favor whoever lost last time
        end else begin
            grant_d = pick(request_i);           // Fixed priority, or nobody eligible in mask
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            grant_q <= 2'b00;
            valid_q <= 1'b0;
            mask_q  <= 2'b01;                    // Master 0 goes first after reset
        end else begin
            grant_q <= grant_d;
            valid_q <= |grant_d;
            if (!hold && (|grant_d)) begin
                mask_q <= ~grant_d;              // New winner goes to the back
            end
        end
    end

    assign grant_o       = grant_q;
    assign grant_valid_o = valid_q;

    // Grant never names both requesters
    a_grant_onehot : assert property (
        @(posedge clk) disable iff (reset_i)
        $onehot0(grant_o)
    ) else $error("wb_arbiter: grant not one-hot");

    // Valid flag tracks the grant register
    a_valid_matches : assert property (
        @(posedge clk) disable iff (reset_i)
        grant_valid_o == (|grant_o)
    ) else $error("wb_arbiter: grant_valid out of step with grant");

endmodule : wb_arbiter

`default_nettype wire

//--- wb_pkg.sv
// Wishbone request and response structs shared by the bus modules
`default_nettype none

`include "wb_defs.svh"

package wb_pkg;

    // Master to slave, classic cycle
    typedef struct packed {
        logic [`WB_ADDR_WIDTH-1:0] adr;  // Word address
        logic [`WB_DATA_WIDTH-1:0] dat;  // Write data
        logic                      we;   // High for write
        logic [`WB_SEL_WIDTH-1:0]  sel;  // Byte lane enables
        logic                      stb;  // Transfer strobe
        logic                      cyc;  // Bus cycle, also the arbiter request
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic [`WB_DATA_WIDTH-1:0] dat;  // Read data, valid with ack
        logic                      ack;  // One pulse per strobe
    } wb_rsp_t;

endpackage : wb_pkg

`default_nettype wire

//--- wb_defs.svh
// Bus width and RAM depth macros for the shared-memory subsystem
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Word address, one address per data word
`define WB_ADDR_WIDTH 8

// Data bus width in bits
`define WB_DATA_WIDTH 32

// One select bit per byte lane
`define WB_SEL_WIDTH (`WB_DATA_WIDTH / 8)

// Full address space is backed by RAM
`define WB_RAM_DEPTH (1 << `WB_ADDR_WIDTH)

// Byte lane width used by the select logic
`define WB_BYTE_WIDTH 8

`endif
